// File: common/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    // group and issue widths
    localparam int RENAME_WIDTH    = 2;
    localparam int DISP_WIDTH      = 2;

    // buffer sizes
    localparam int INTDQ_DEPTH     = 8;
    localparam int MEMDQ_DEPTH     = 8;
    localparam int IMMBUF_DEPTH    = 8;
    localparam int IMM_READ_PORTS  = 2;
    localparam int IMM_CLEAR_PORTS = 2;

    // field widths
    localparam int ROB_IDX_W       = 5;
    localparam int IROB_IDX_W      = 3;
    localparam int IMM_W           = 20;
    localparam int SEQ_W           = 8;
    localparam int IQ_ID_W         = 2;

    // queue entry layouts, low to high: seq, rob idx, irob idx, iq id
    localparam int INT_ENTRY_W     = SEQ_W + ROB_IDX_W + IROB_IDX_W + IQ_ID_W;
    // memory entry adds the wait flag and dependency index on top
    localparam int MEM_ENTRY_W     = INT_ENTRY_W + 1 + ROB_IDX_W;

    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [IROB_IDX_W-1:0] irob_idx_t;
    typedef logic [IMM_W-1:0]      imm_t;
    typedef logic [SEQ_W-1:0]      seq_t;

    typedef enum logic [1:0] {
        INT_BLOCK,
        MEM_BLOCK,
        UNKNOWN_BLOCK
    } disp_block_e;

    // IQ_SCU marks a serializing micro-op
    typedef enum logic [IQ_ID_W-1:0] {
        IQ_ALU,
        IQ_SCU,
        IQ_LOAD,
        IQ_STORE
    } iq_id_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_ILLEGAL,
        EXC_MISALIGNED,
        EXC_FETCH_FAULT
    } except_e;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_DRAIN,
        SER_ISSUE,
        SER_WAIT
    } ser_state_e;

endpackage

`default_nettype wire

// File: verilog/disp_queue.sv
`default_nettype none

module disp_queue #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 16
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  i_flush,

    output logic o_can_enq,
    input  wire  i_enq_vld,
    input  wire  [dispatch_pkg::RENAME_WIDTH-1:0] i_enq_req,
    input  wire  [dispatch_pkg::RENAME_WIDTH-1:0][WIDTH-1:0] i_enq_data,

    output logic [dispatch_pkg::DISP_WIDTH-1:0] o_deq_vld,
    output logic [dispatch_pkg::DISP_WIDTH-1:0][WIDTH-1:0] o_deq_data,
    input  wire  [dispatch_pkg::DISP_WIDTH-1:0] i_deq_rdy
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] enq_num;
    logic [CNT_W-1:0] deq_num;
    logic [PTR_W-1:0] enq_slot [dispatch_pkg::RENAME_WIDTH];
    logic do_enq;

    // circular pointer advance, off never reaches DEPTH
    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr, input int off);
        int sum;
        sum = int'(ptr) + off;
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return PTR_W'(sum);
    endfunction

    // compact requested lanes onto consecutive tail slots
    always_comb begin
        int n;
        n = 0;
        for (int k = 0; k < dispatch_pkg::RENAME_WIDTH; k++) begin
            enq_slot[k] = ptr_add(tail, n);
            if (i_enq_req[k]) begin
                n = n + 1;
            end
        end
        enq_num = CNT_W'(n);
    end

    // oldest entries at the head, ready is a prefix of valid
    always_comb begin
        int n;
        n = 0;
        for (int k = 0; k < dispatch_pkg::DISP_WIDTH; k++) begin
            o_deq_vld[k]  = int'(count) > k;
            o_deq_data[k] = mem[ptr_add(head, k)];
            if (o_deq_vld[k] && i_deq_rdy[k]) begin
                n = n + 1;
            end
        end
        deq_num = CNT_W'(n);
    end

    assign o_can_enq = (int'(count) + int'(enq_num)) <= DEPTH;
    assign do_enq    = i_enq_vld && o_can_enq;

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else begin
            head <= ptr_add(head, int'(deq_num));
            if (do_enq) begin
                tail <= ptr_add(tail, int'(enq_num));
            end
            count <= count + (do_enq ? enq_num : CNT_W'(0)) - deq_num;
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            for (int k = 0; k < dispatch_pkg::RENAME_WIDTH; k++) begin
                if (i_enq_req[k]) begin
                    mem[enq_slot[k]] <= i_enq_data[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/imm_buffer.sv
`default_nettype none

module imm_buffer (
    input  wire  clk,
    input  wire  rst,
    input  wire  i_flush,

    output logic o_can_alloc,
    input  wire  i_alloc_vld,
    input  wire  [dispatch_pkg::RENAME_WIDTH-1:0] i_alloc_req,
    input  dispatch_pkg::imm_t [dispatch_pkg::RENAME_WIDTH-1:0] i_alloc_imm,
    output dispatch_pkg::irob_idx_t [dispatch_pkg::RENAME_WIDTH-1:0] o_alloc_idx,

    input  dispatch_pkg::irob_idx_t [dispatch_pkg::IMM_READ_PORTS-1:0] i_read_idx,
    output dispatch_pkg::imm_t [dispatch_pkg::IMM_READ_PORTS-1:0] o_read_imm,

    input  wire  [dispatch_pkg::IMM_CLEAR_PORTS-1:0] i_clear_vld,
    input  dispatch_pkg::irob_idx_t [dispatch_pkg::IMM_CLEAR_PORTS-1:0] i_clear_idx
);
    dispatch_pkg::imm_t mem [dispatch_pkg::IMMBUF_DEPTH];
    logic [dispatch_pkg::IMMBUF_DEPTH-1:0] used;
    logic [dispatch_pkg::RENAME_WIDTH-1:0] found;

    // lowest free entry per lane, earlier lanes claim first
    always_comb begin
        logic [dispatch_pkg::IMMBUF_DEPTH-1:0] taken;
        taken = used;
        for (int k = 0; k < dispatch_pkg::RENAME_WIDTH; k++) begin
            o_alloc_idx[k] = '0;
            found[k]       = 1'b0;
            if (i_alloc_req[k]) begin
                for (int e = dispatch_pkg::IMMBUF_DEPTH - 1; e >= 0; e--) begin
                    if (!taken[e]) begin
                        o_alloc_idx[k] = dispatch_pkg::irob_idx_t'(e);
                        found[k]       = 1'b1;
                    end
                end
                if (found[k]) begin
                    taken[o_alloc_idx[k]] = 1'b1;
                end
            end
        end
    end

    assign o_can_alloc = &(found | ~i_alloc_req);

    always_comb begin
        for (int p = 0; p < dispatch_pkg::IMM_READ_PORTS; p++) begin
            o_read_imm[p] = mem[i_read_idx[p]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            used <= '0;
        end
        else begin
            for (int c = 0; c < dispatch_pkg::IMM_CLEAR_PORTS; c++) begin
                if (i_clear_vld[c]) begin
                    used[i_clear_idx[c]] <= 1'b0;
                end
            end
            // allocated entries are free, so no clash with clears
            if (i_alloc_vld && o_can_alloc) begin
                for (int k = 0; k < dispatch_pkg::RENAME_WIDTH; k++) begin
                    if (i_alloc_req[k]) begin
                        used[o_alloc_idx[k]] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc_vld && o_can_alloc) begin
            for (int k = 0; k < dispatch_pkg::RENAME_WIDTH; k++) begin
                if (i_alloc_req[k]) begin
                    mem[o_alloc_idx[k]] <= i_alloc_imm[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/serialize_gate.sv
`default_nettype none

module serialize_gate (
    input  wire  clk,
    input  wire  rst,
    input  wire  i_flush,
    input  wire  [dispatch_pkg::DISP_WIDTH-1:0] i_queue_vld,
    input  dispatch_pkg::iq_id_e [dispatch_pkg::DISP_WIDTH-1:0] i_queue_iq_id,
    input  wire  i_can_dispatch_serialize,
    input  wire  i_commit_serialize,
    output logic [dispatch_pkg::DISP_WIDTH-1:0] o_issue_mask
);
    dispatch_pkg::ser_state_e ser_state;
    logic [dispatch_pkg::DISP_WIDTH-1:0] is_scu;
    logic [dispatch_pkg::DISP_WIDTH-1:0] front_run;

    // leading run of valid non-scu entries
    always_comb begin
        logic run;
        run = 1'b1;
        for (int k = 0; k < dispatch_pkg::DISP_WIDTH; k++) begin
            is_scu[k]    = i_queue_vld[k] && (i_queue_iq_id[k] == dispatch_pkg::IQ_SCU);
            run          = run && i_queue_vld[k] && !is_scu[k];
            front_run[k] = run;
        end
    end

    always_comb begin
        case (ser_state)
            dispatch_pkg::SER_IDLE:  o_issue_mask = front_run;
            // slot 0 holds the scu micro-op here
            dispatch_pkg::SER_ISSUE: o_issue_mask = dispatch_pkg::DISP_WIDTH'(1);
            default:                 o_issue_mask = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            ser_state <= dispatch_pkg::SER_IDLE;
        end
        else begin
            case (ser_state)
                dispatch_pkg::SER_IDLE: begin
                    if (|is_scu) begin
                        ser_state <= dispatch_pkg::SER_DRAIN;
                    end
                end
                dispatch_pkg::SER_DRAIN: begin
                    if (i_can_dispatch_serialize) begin
                        ser_state <= dispatch_pkg::SER_ISSUE;
                    end
                end
                // consumer takes slot 0 in the issue cycle
                dispatch_pkg::SER_ISSUE: ser_state <= dispatch_pkg::SER_WAIT;
                dispatch_pkg::SER_WAIT: begin
                    if (i_commit_serialize) begin
                        ser_state <= dispatch_pkg::SER_IDLE;
                    end
                end
                default: ser_state <= dispatch_pkg::SER_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dispatch/dispatch.sv
`default_nettype none

module dispatch (
    input  wire  clk,
    input  wire  rst,

    input  wire  i_squash_vld,
    input  wire  i_can_dispatch_serialize,
    input  wire  i_commit_serialize,

    // back to rename
    output logic o_stall,

    // rename group
    input  wire  [dispatch_pkg::RENAME_WIDTH-1:0] i_enq_vld,
    input  dispatch_pkg::disp_block_e [dispatch_pkg::RENAME_WIDTH-1:0] i_block,
    input  dispatch_pkg::iq_id_e [dispatch_pkg::RENAME_WIDTH-1:0] i_iq_id,
    input  wire  [dispatch_pkg::RENAME_WIDTH-1:0] i_is_mv,
    input  wire  [dispatch_pkg::RENAME_WIDTH-1:0] i_use_imm,
    input  dispatch_pkg::imm_t [dispatch_pkg::RENAME_WIDTH-1:0] i_imm,
    input  wire  [dispatch_pkg::RENAME_WIDTH-1:0] i_has_except,
    input  dispatch_pkg::except_e [dispatch_pkg::RENAME_WIDTH-1:0] i_except,
    input  dispatch_pkg::seq_t [dispatch_pkg::RENAME_WIDTH-1:0] i_seq,

    // memory-dependence predictor
    input  wire  [dispatch_pkg::RENAME_WIDTH-1:0] i_mem_wait,
    input  dispatch_pkg::rob_idx_t [dispatch_pkg::RENAME_WIDTH-1:0] i_mem_dep_idx,

    // reorder buffer
    input  wire  i_can_insert_rob,
    input  dispatch_pkg::rob_idx_t [dispatch_pkg::RENAME_WIDTH-1:0] i_alloc_rob_idx,
    output logic o_insert_rob_vld,
    output logic [dispatch_pkg::RENAME_WIDTH-1:0] o_insert_rob_req,
    output logic [dispatch_pkg::RENAME_WIDTH-1:0] o_insert_rob_ismv,
    output dispatch_pkg::seq_t [dispatch_pkg::RENAME_WIDTH-1:0] o_rob_seq,

    // integer issue
    output logic [dispatch_pkg::DISP_WIDTH-1:0] o_int_vld,
    output dispatch_pkg::seq_t [dispatch_pkg::DISP_WIDTH-1:0] o_int_seq,
    output dispatch_pkg::rob_idx_t [dispatch_pkg::DISP_WIDTH-1:0] o_int_rob_idx,
    output dispatch_pkg::irob_idx_t [dispatch_pkg::DISP_WIDTH-1:0] o_int_irob_idx,
    output dispatch_pkg::iq_id_e [dispatch_pkg::DISP_WIDTH-1:0] o_int_iq_id,
    input  wire  [dispatch_pkg::DISP_WIDTH-1:0] i_int_rdy,

    // memory issue
    output logic [dispatch_pkg::DISP_WIDTH-1:0] o_mem_vld,
    output dispatch_pkg::seq_t [dispatch_pkg::DISP_WIDTH-1:0] o_mem_seq,
    output dispatch_pkg::rob_idx_t [dispatch_pkg::DISP_WIDTH-1:0] o_mem_rob_idx,
    output dispatch_pkg::irob_idx_t [dispatch_pkg::DISP_WIDTH-1:0] o_mem_irob_idx,
    output dispatch_pkg::iq_id_e [dispatch_pkg::DISP_WIDTH-1:0] o_mem_iq_id,
    output logic [dispatch_pkg::DISP_WIDTH-1:0] o_mem_wait,
    output dispatch_pkg::rob_idx_t [dispatch_pkg::DISP_WIDTH-1:0] o_mem_dep_idx,
    input  wire  [dispatch_pkg::DISP_WIDTH-1:0] i_mem_rdy,

    // immediate buffer
    input  dispatch_pkg::irob_idx_t [dispatch_pkg::IMM_READ_PORTS-1:0] i_read_irob_idx,
    output dispatch_pkg::imm_t [dispatch_pkg::IMM_READ_PORTS-1:0] o_read_imm,
    input  wire  [dispatch_pkg::IMM_CLEAR_PORTS-1:0] i_clear_vld,
    input  dispatch_pkg::irob_idx_t [dispatch_pkg::IMM_CLEAR_PORTS-1:0] i_clear_idx,

    // frontend exception
    output logic o_exceptwb_vld,
    output dispatch_pkg::rob_idx_t o_exceptwb_rob_idx,
    output dispatch_pkg::except_e o_exceptwb_type
);
    logic can_insert_int;
    logic can_insert_mem;
    logic can_alloc_imm;
    logic can_dispatch;
    logic exc_any;
    logic [dispatch_pkg::RENAME_WIDTH-1:0] int_req;
    logic [dispatch_pkg::RENAME_WIDTH-1:0] mem_req;
    logic [dispatch_pkg::RENAME_WIDTH-1:0] imm_req;
    logic [dispatch_pkg::RENAME_WIDTH-1:0][dispatch_pkg::INT_ENTRY_W-1:0] int_entry;
    logic [dispatch_pkg::RENAME_WIDTH-1:0][dispatch_pkg::MEM_ENTRY_W-1:0] mem_entry;
    dispatch_pkg::irob_idx_t [dispatch_pkg::RENAME_WIDTH-1:0] irob_alloc_idx;
    logic [dispatch_pkg::DISP_WIDTH-1:0] int_q_vld;
    logic [dispatch_pkg::DISP_WIDTH-1:0] ser_mask;
    logic [dispatch_pkg::DISP_WIDTH-1:0][dispatch_pkg::INT_ENTRY_W-1:0] int_deq_data;
    logic [dispatch_pkg::DISP_WIDTH-1:0][dispatch_pkg::MEM_ENTRY_W-1:0] mem_deq_data;
    logic [dispatch_pkg::DISP_WIDTH-1:0][dispatch_pkg::IQ_ID_W-1:0] int_iq_raw;
    logic [dispatch_pkg::DISP_WIDTH-1:0][dispatch_pkg::IQ_ID_W-1:0] mem_iq_raw;

    // moves skip the integer queue and need no immediate
    always_comb begin
        for (int k = 0; k < dispatch_pkg::RENAME_WIDTH; k++) begin
            int_req[k] = i_enq_vld[k] && (i_block[k] == dispatch_pkg::INT_BLOCK) && !i_is_mv[k];
            mem_req[k] = i_enq_vld[k] && (i_block[k] == dispatch_pkg::MEM_BLOCK);
            imm_req[k] = i_enq_vld[k] && i_use_imm[k] && !i_is_mv[k];
            o_insert_rob_ismv[k] = i_is_mv[k] || (i_block[k] == dispatch_pkg::UNKNOWN_BLOCK);
            int_entry[k] = {i_iq_id[k], irob_alloc_idx[k], i_alloc_rob_idx[k], i_seq[k]};
            mem_entry[k] = {i_mem_dep_idx[k], i_mem_wait[k], i_iq_id[k], irob_alloc_idx[k],
                            i_alloc_rob_idx[k], i_seq[k]};
        end
    end

    // whole group or nothing
    assign can_dispatch     = i_can_insert_rob && can_insert_int && can_insert_mem && can_alloc_imm;
    assign o_insert_rob_vld = can_dispatch;
    assign o_insert_rob_req = i_enq_vld;
    assign o_rob_seq        = i_seq;
    assign o_stall          = i_enq_vld[0] && !can_dispatch;

    // walk down so the lowest lane wins
    always_comb begin
        exc_any            = 1'b0;
        o_exceptwb_rob_idx = '0;
        o_exceptwb_type    = dispatch_pkg::EXC_NONE;
        for (int k = dispatch_pkg::RENAME_WIDTH - 1; k >= 0; k--) begin
            if (i_enq_vld[k] && i_has_except[k]) begin
                exc_any            = 1'b1;
                o_exceptwb_rob_idx = i_alloc_rob_idx[k];
                o_exceptwb_type    = i_except[k];
            end
        end
    end

    assign o_exceptwb_vld = can_dispatch && exc_any;

    always_comb begin
        for (int k = 0; k < dispatch_pkg::DISP_WIDTH; k++) begin
            {int_iq_raw[k], o_int_irob_idx[k], o_int_rob_idx[k], o_int_seq[k]} = int_deq_data[k];
            o_int_iq_id[k] = dispatch_pkg::iq_id_e'(int_iq_raw[k]);
            {o_mem_dep_idx[k], o_mem_wait[k], mem_iq_raw[k], o_mem_irob_idx[k],
             o_mem_rob_idx[k], o_mem_seq[k]} = mem_deq_data[k];
            o_mem_iq_id[k] = dispatch_pkg::iq_id_e'(mem_iq_raw[k]);
        end
    end

    assign o_int_vld = int_q_vld & ser_mask;

    disp_queue #(
        .DEPTH(dispatch_pkg::INTDQ_DEPTH),
        .WIDTH(dispatch_pkg::INT_ENTRY_W)
    ) u_int_queue (
        .clk       (clk),
        .rst       (rst),
        .i_flush   (i_squash_vld),
        .o_can_enq (can_insert_int),
        .i_enq_vld (can_dispatch),
        .i_enq_req (int_req),
        .i_enq_data(int_entry),
        .o_deq_vld (int_q_vld),
        .o_deq_data(int_deq_data),
        .i_deq_rdy (i_int_rdy & o_int_vld)
    );

    disp_queue #(
        .DEPTH(dispatch_pkg::MEMDQ_DEPTH),
        .WIDTH(dispatch_pkg::MEM_ENTRY_W)
    ) u_mem_queue (
        .clk       (clk),
        .rst       (rst),
        .i_flush   (i_squash_vld),
        .o_can_enq (can_insert_mem),
        .i_enq_vld (can_dispatch),
        .i_enq_req (mem_req),
        .i_enq_data(mem_entry),
        .o_deq_vld (o_mem_vld),
        .o_deq_data(mem_deq_data),
        .i_deq_rdy (i_mem_rdy)
    );

    imm_buffer u_imm_buffer (
        .clk        (clk),
        .rst        (rst),
        .i_flush    (i_squash_vld),
        .o_can_alloc(can_alloc_imm),
        .i_alloc_vld(can_dispatch),
        .i_alloc_req(imm_req),
        .i_alloc_imm(i_imm),
        .o_alloc_idx(irob_alloc_idx),
        .i_read_idx (i_read_irob_idx),
        .o_read_imm (o_read_imm),
        .i_clear_vld(i_clear_vld),
        .i_clear_idx(i_clear_idx)
    );

    serialize_gate u_serialize_gate (
        .clk                     (clk),
        .rst                     (rst),
        .i_flush                 (i_squash_vld),
        .i_queue_vld             (int_q_vld),
        .i_queue_iq_id           (o_int_iq_id),
        .i_can_dispatch_serialize(i_can_dispatch_serialize),
        .i_commit_serialize      (i_commit_serialize),
        .o_issue_mask            (ser_mask)
    );

endmodule

`default_nettype wire

// File: verification/dispatch_props.sv
`default_nettype none

module dispatch_props (
    input wire clk,
    input wire rst,
    input wire i_squash_vld,
    input wire o_stall,
    input wire [1:0] o_int_vld,
    input wire [1:0] o_mem_vld,
    input wire [1:0] i_int_rdy,
    input dispatch_pkg::ser_state_e ser_state,
    input wire [$clog2(dispatch_pkg::INTDQ_DEPTH + 1)-1:0] int_count,
    input wire [$clog2(dispatch_pkg::MEMDQ_DEPTH + 1)-1:0] mem_count
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // queues come back empty one edge after a squash
    a_squash_empty: assert property (@(posedge clk) disable iff (rst)
        i_squash_vld |=> (o_int_vld == 2'b00 && o_mem_vld == 2'b00))
        else begin
            fail_count++;
            $error("queue valid in the cycle after squash");
        end

    // a held group leaves both queues no fuller
    a_stall_no_write: assert property (@(posedge clk) disable iff (rst)
        o_stall |=> (int_count <= $past(int_count) && mem_count <= $past(mem_count)))
        else begin
            fail_count++;
            $error("stalled group was written to a queue");
        end

    // the serializing micro-op must be taken in its issue cycle
    a_ser_issue_taken: assert property (@(posedge clk) disable iff (rst)
        (ser_state == dispatch_pkg::SER_ISSUE) |-> i_int_rdy[0])
        else begin
            fail_count++;
            $error("serializing micro-op not taken in issue cycle");
        end

endmodule

bind dispatch dispatch_props u_props (
    .clk         (clk),
    .rst         (rst),
    .i_squash_vld(i_squash_vld),
    .o_stall     (o_stall),
    .o_int_vld   (o_int_vld),
    .o_mem_vld   (o_mem_vld),
    .i_int_rdy   (i_int_rdy),
    .ser_state   (u_serialize_gate.ser_state),
    .int_count   (u_int_queue.count),
    .mem_count   (u_mem_queue.count)
);

`default_nettype wire

// File: verification/tb_dispatch.sv
`default_nettype none

module tb_dispatch;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CASES = 64;
    localparam int NUM_FIELDS = 31;
    localparam int RESET_CYCLES = 8;

    logic clk;
    logic rst;
    logic i_squash_vld;
    logic i_can_dispatch_serialize;
    logic i_commit_serialize;
    logic o_stall;
    logic [1:0] i_enq_vld;
    dispatch_pkg::disp_block_e [1:0] i_block;
    dispatch_pkg::iq_id_e [1:0] i_iq_id;
    logic [1:0] i_is_mv;
    logic [1:0] i_use_imm;
    dispatch_pkg::imm_t [1:0] i_imm;
    logic [1:0] i_has_except;
    dispatch_pkg::except_e [1:0] i_except;
    dispatch_pkg::seq_t [1:0] i_seq;
    logic [1:0] i_mem_wait;
    dispatch_pkg::rob_idx_t [1:0] i_mem_dep_idx;
    logic i_can_insert_rob;
    dispatch_pkg::rob_idx_t [1:0] i_alloc_rob_idx;
    logic o_insert_rob_vld;
    logic [1:0] o_insert_rob_req;
    logic [1:0] o_insert_rob_ismv;
    dispatch_pkg::seq_t [1:0] o_rob_seq;
    logic [1:0] o_int_vld;
    dispatch_pkg::seq_t [1:0] o_int_seq;
    dispatch_pkg::rob_idx_t [1:0] o_int_rob_idx;
    dispatch_pkg::irob_idx_t [1:0] o_int_irob_idx;
    dispatch_pkg::iq_id_e [1:0] o_int_iq_id;
    logic [1:0] i_int_rdy;
    logic [1:0] o_mem_vld;
    dispatch_pkg::seq_t [1:0] o_mem_seq;
    dispatch_pkg::rob_idx_t [1:0] o_mem_rob_idx;
    dispatch_pkg::irob_idx_t [1:0] o_mem_irob_idx;
    dispatch_pkg::iq_id_e [1:0] o_mem_iq_id;
    logic [1:0] o_mem_wait;
    dispatch_pkg::rob_idx_t [1:0] o_mem_dep_idx;
    logic [1:0] i_mem_rdy;
    dispatch_pkg::irob_idx_t [1:0] i_read_irob_idx;
    dispatch_pkg::imm_t [1:0] o_read_imm;
    logic [1:0] i_clear_vld;
    dispatch_pkg::irob_idx_t [1:0] i_clear_idx;
    logic o_exceptwb_vld;
    dispatch_pkg::rob_idx_t o_exceptwb_rob_idx;
    dispatch_pkg::except_e o_exceptwb_type;

    // one row per cycle, columns as in the case file header
    logic [19:0] cases_f [MAX_CASES][NUM_FIELDS];
    string case_name [MAX_CASES];
    int num_cases = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycle_limit = 0;

    // expected entry fields per sequence tag
    dispatch_pkg::iq_id_e exp_iq [256];
    dispatch_pkg::irob_idx_t exp_irob [256];
    logic exp_imm [256];
    logic [dispatch_pkg::IMMBUF_DEPTH-1:0] imm_used = '0;

    dispatch dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // lane kinds: 0 alu, 1 scu, 2 load, 3 store, 4 move, 5 unknown block
    task automatic set_lane(input int k, input logic [19:0] kind);
        i_block[k] = (kind == 2 || kind == 3) ? dispatch_pkg::MEM_BLOCK :
                     (kind == 5) ? dispatch_pkg::UNKNOWN_BLOCK : dispatch_pkg::INT_BLOCK;
        i_iq_id[k] = (kind == 1) ? dispatch_pkg::IQ_SCU :
                     (kind == 2) ? dispatch_pkg::IQ_LOAD :
                     (kind == 3) ? dispatch_pkg::IQ_STORE : dispatch_pkg::IQ_ALU;
        i_is_mv[k] = (kind == 4);
    endtask

    task automatic apply_case(input int i);
        i_enq_vld = cases_f[i][0][1:0];
        i_use_imm = cases_f[i][3][1:0];
        for (int k = 0; k < 2; k++) begin
            set_lane(k, cases_f[i][1 + k]);
            i_imm[k]           = cases_f[i][4 + k];
            i_has_except[k]    = cases_f[i][6 + k] != 0;
            i_except[k]        = dispatch_pkg::except_e'(cases_f[i][6 + k][1:0]);
            i_seq[k]           = cases_f[i][8 + k][7:0];
            i_alloc_rob_idx[k] = cases_f[i][8 + k][4:0];
            // predictor fields derived from the tag
            i_mem_wait[k]      = cases_f[i][8 + k][0];
            i_mem_dep_idx[k]   = cases_f[i][8 + k][5:1];
        end
        i_can_insert_rob         = cases_f[i][10][0];
        i_int_rdy                = cases_f[i][11][1:0];
        i_mem_rdy                = cases_f[i][12][1:0];
        i_squash_vld             = cases_f[i][13][0];
        i_can_dispatch_serialize = cases_f[i][14][0];
        i_commit_serialize       = cases_f[i][15][0];
        // 9 reads the entry named by integer slot 0
        i_read_irob_idx[0] = (cases_f[i][16] == 9) ? o_int_irob_idx[0] : cases_f[i][16][2:0];
        i_read_irob_idx[1] = i_read_irob_idx[0];
        i_clear_vld[0]     = cases_f[i][17][3];
        i_clear_idx[0]     = cases_f[i][17][2:0];
    endtask

    task automatic check_val(input int i, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s %s expected %h actual %h", case_name[i], what, exp, act);
        end
    endtask

    task automatic check_int_slot(input int i, input int k);
        dispatch_pkg::seq_t seq;
        seq = cases_f[i][25 + k][7:0];
        check_val(i, $sformatf("int_seq%0d", k), seq, o_int_seq[k]);
        check_val(i, $sformatf("int_rob%0d", k), seq[4:0], o_int_rob_idx[k]);
        check_val(i, $sformatf("int_iq%0d", k), exp_iq[seq], o_int_iq_id[k]);
        if (exp_imm[seq]) begin
            check_val(i, $sformatf("int_irob%0d", k), exp_irob[seq], o_int_irob_idx[k]);
        end
    endtask

    task automatic check_mem_slot(input int i, input int k);
        dispatch_pkg::seq_t seq;
        seq = cases_f[i][28 + k][7:0];
        check_val(i, $sformatf("mem_seq%0d", k), seq, o_mem_seq[k]);
        check_val(i, $sformatf("mem_rob%0d", k), seq[4:0], o_mem_rob_idx[k]);
        check_val(i, $sformatf("mem_iq%0d", k), exp_iq[seq], o_mem_iq_id[k]);
        check_val(i, $sformatf("mem_wait%0d", k), seq[0], o_mem_wait[k]);
        check_val(i, $sformatf("mem_dep%0d", k), seq[5:1], o_mem_dep_idx[k]);
        if (exp_imm[seq]) begin
            check_val(i, $sformatf("mem_irob%0d", k), exp_irob[seq], o_mem_irob_idx[k]);
        end
    endtask

    task automatic check_case(input int i);
        check_val(i, "stall", cases_f[i][18], o_stall);
        check_val(i, "rob_insert", cases_f[i][19], o_insert_rob_vld);
        check_val(i, "rob_req", cases_f[i][0], o_insert_rob_req);
        check_val(i, "ismv", cases_f[i][20], o_insert_rob_ismv);
        check_val(i, "exc_vld", cases_f[i][21], o_exceptwb_vld);
        if (cases_f[i][21][0]) begin
            check_val(i, "exc_type", cases_f[i][22], o_exceptwb_type);
            check_val(i, "exc_rob", cases_f[i][23], o_exceptwb_rob_idx);
        end
        check_val(i, "int_vld", cases_f[i][24], o_int_vld);
        check_val(i, "mem_vld", cases_f[i][27], o_mem_vld);
        for (int k = 0; k < 2; k++) begin
            if (cases_f[i][0][k]) begin
                check_val(i, $sformatf("rob_seq%0d", k), cases_f[i][8 + k], o_rob_seq[k]);
            end
            if (cases_f[i][24][k]) begin
                check_int_slot(i, k);
            end
            if (cases_f[i][27][k]) begin
                check_mem_slot(i, k);
            end
        end
        if (cases_f[i][16] != 8) begin
            check_val(i, "read_imm0", cases_f[i][30], o_read_imm[0]);
            check_val(i, "read_imm1", cases_f[i][30], o_read_imm[1]);
        end
    endtask

    // immediate buffer model hands out the lowest free entry in lane order
    task automatic record_group(input int i);
        dispatch_pkg::seq_t seq;
        int slot;
        if (cases_f[i][19][0]) begin
            for (int k = 0; k < 2; k++) begin
                seq = i_seq[k];
                if (i_enq_vld[k]) begin
                    exp_iq[seq]  = i_iq_id[k];
                    exp_imm[seq] = i_use_imm[k] && !i_is_mv[k];
                end
                if (i_enq_vld[k] && i_use_imm[k] && !i_is_mv[k]) begin
                    slot = 0;
                    while (slot < dispatch_pkg::IMMBUF_DEPTH && imm_used[slot]) begin
                        slot++;
                    end
                    if (slot < dispatch_pkg::IMMBUF_DEPTH) begin
                        exp_irob[seq]  = dispatch_pkg::irob_idx_t'(slot);
                        imm_used[slot] = 1'b1;
                    end
                end
            end
        end
        if (i_clear_vld[0]) begin
            imm_used[i_clear_idx[0]] = 1'b0;
        end
        if (i_squash_vld) begin
            imm_used = '0;
        end
    endtask

    initial begin
        int fd;
        int rc;
        string tok;
        string line;
        logic [19:0] val;
        clk = 0;
        rst = 1;
        {i_squash_vld, i_can_dispatch_serialize, i_commit_serialize} = '0;
        {i_enq_vld, i_is_mv, i_use_imm, i_imm, i_has_except, i_seq} = '0;
        i_block = '{default: dispatch_pkg::INT_BLOCK};
        i_iq_id = '{default: dispatch_pkg::IQ_ALU};
        i_except = '{default: dispatch_pkg::EXC_NONE};
        {i_mem_wait, i_mem_dep_idx, i_can_insert_rob, i_alloc_rob_idx} = '0;
        {i_int_rdy, i_mem_rdy, i_read_irob_idx, i_clear_vld, i_clear_idx} = '0;

        fd = $fopen("verification/dispatch_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            errors++;
        end
        else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    rc = $fgets(line, fd);
                end
                else if (num_cases < MAX_CASES) begin
                    case_name[num_cases] = tok;
                    for (int j = 0; j < NUM_FIELDS; j++) begin
                        rc = $fscanf(fd, "%h", val);
                        cases_f[num_cases][j] = val;
                    end
                    num_cases++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = 2 * num_cases + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 0;
        for (int i = 0; i < num_cases; i++) begin
            @(posedge clk);
            #1 apply_case(i);
            #2 check_case(i);
            record_group(i);
        end

        errors += dut.u_props.fail_count;
        if (num_cases == 0) begin
            $display("no cases were read from the case file");
            errors++;
        end
        $display("cases %0d checks %0d errors %0d", num_cases, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/dispatch_cases.txt
# name vld k0 k1 uimm imm0 imm1 exc0 exc1 seq0 seq1 rob irdy mrdy squash cds commit rd clr
# then expected: stall ins ismv excv exct excrob ivld iseq0 iseq1 mvld mseq0 mseq1 rdimm
route0 3 0 2 1 abc 000 0 0 01 02 1 0 0 0 0 0 8 0 0 1 0 0 0 00 0 00 00 0 00 00 000
route1 3 4 5 1 111 222 0 0 03 04 1 0 0 0 0 0 0 0 0 1 3 0 0 00 1 01 00 1 02 00 abc
route2 3 3 0 2 000 5a5 0 0 05 06 1 1 1 0 0 0 8 0 0 1 0 0 0 00 1 01 00 1 02 00 000
imm_rd 0 0 0 0 000 000 0 0 00 00 1 0 0 0 0 0 9 8 0 1 0 0 0 00 1 06 00 1 05 00 5a5
imm_reuse 1 0 0 1 777 000 0 0 07 00 1 1 1 0 0 0 8 0 0 1 0 0 0 00 1 06 00 1 05 00 000
imm_chk 0 0 0 0 000 000 0 0 00 00 1 1 0 0 0 0 9 8 0 1 0 0 0 00 1 07 00 0 00 00 777
rob_bp 3 0 2 0 000 000 1 2 08 09 0 0 0 0 0 0 8 0 1 0 0 0 0 00 0 00 00 0 00 00 000
exc_acc 3 0 2 0 000 000 1 2 08 09 1 0 0 0 0 0 8 0 0 1 0 1 1 08 0 00 00 0 00 00 000
mfill0 3 2 2 0 000 000 0 0 0a 0b 1 0 0 0 0 0 8 0 0 1 0 0 0 00 1 08 00 1 09 00 000
mfill1 3 2 2 0 000 000 0 0 0c 0d 1 0 0 0 0 0 8 0 0 1 0 0 0 00 1 08 00 3 09 0a 000
mfill2 3 2 2 0 000 000 0 0 0e 0f 1 0 0 0 0 0 8 0 0 1 0 0 0 00 1 08 00 3 09 0a 000
mfull 3 2 2 0 000 000 0 0 10 11 1 0 0 0 0 0 8 0 1 0 0 0 0 00 1 08 00 3 09 0a 000
mdrain 3 2 2 0 000 000 0 0 10 11 1 0 3 0 0 0 8 0 1 0 0 0 0 00 1 08 00 3 09 0a 000
mretry 3 2 2 0 000 000 0 0 10 11 1 0 3 0 0 0 8 0 0 1 0 0 0 00 1 08 00 3 0b 0c 000
mdrain2 0 0 0 0 000 000 0 0 00 00 1 0 3 0 0 0 8 0 0 1 0 0 0 00 1 08 00 3 0d 0e 000
mdrain3 0 0 0 0 000 000 0 0 00 00 1 0 3 0 0 0 8 0 0 1 0 0 0 00 1 08 00 3 0f 10 000
mdrain4 0 0 0 0 000 000 0 0 00 00 1 0 1 0 0 0 8 0 0 1 0 0 0 00 1 08 00 1 11 00 000
ser_in 3 0 1 0 000 000 0 0 12 13 1 0 0 0 0 0 8 0 0 1 0 0 0 00 1 08 00 0 00 00 000
ser_old 1 0 0 0 000 000 0 0 14 00 1 3 0 0 0 0 8 0 0 1 0 0 0 00 3 08 12 0 00 00 000
ser_seen 0 0 0 0 000 000 0 0 00 00 1 0 0 0 0 0 8 0 0 1 0 0 0 00 0 00 00 0 00 00 000
ser_drain 0 0 0 0 000 000 0 0 00 00 1 0 0 0 0 0 8 0 0 1 0 0 0 00 0 00 00 0 00 00 000
ser_perm 0 0 0 0 000 000 0 0 00 00 1 0 0 0 1 0 8 0 0 1 0 0 0 00 0 00 00 0 00 00 000
ser_issue 0 0 0 0 000 000 0 0 00 00 1 1 0 0 0 0 8 0 0 1 0 0 0 00 1 13 00 0 00 00 000
ser_wait 0 0 0 0 000 000 0 0 00 00 1 0 0 0 0 0 8 0 0 1 0 0 0 00 0 00 00 0 00 00 000
ser_cmt 0 0 0 0 000 000 0 0 00 00 1 0 0 0 0 1 8 0 0 1 0 0 0 00 0 00 00 0 00 00 000
ser_resume 0 0 0 0 000 000 0 0 00 00 1 1 0 0 0 0 8 0 0 1 0 0 0 00 1 14 00 0 00 00 000
sq_fill 3 0 2 3 aaa bbb 0 0 15 16 1 0 0 0 0 0 8 0 0 1 0 0 0 00 0 00 00 0 00 00 000
sq_go 0 0 0 0 000 000 0 0 00 00 1 0 0 1 0 0 8 0 0 1 0 0 0 00 1 15 00 1 16 00 000
sq_empty 1 0 0 1 ccc 000 0 0 17 00 1 0 0 0 0 0 8 0 0 1 0 0 0 00 0 00 00 0 00 00 000
sq_imm 0 0 0 0 000 000 0 0 00 00 1 1 0 0 0 0 0 0 0 1 0 0 0 00 1 17 00 0 00 00 ccc

// File: sources.f
common/dispatch_pkg.sv
verilog/disp_queue.sv
verilog/imm_buffer.sv
verilog/serialize_gate.sv
dispatch/dispatch.sv
verification/dispatch_props.sv
verification/tb_dispatch.sv

// File: Bender.yml
package:
  name: dispatch

sources:
  - common/dispatch_pkg.sv
  - verilog/disp_queue.sv
  - verilog/imm_buffer.sv
  - verilog/serialize_gate.sv
  - dispatch/dispatch.sv
  - target: test
    files:
      - verification/dispatch_props.sv
      - verification/tb_dispatch.sv
